// File: Bender.yml
package:
  name: vec_decode

sources:
  - include_dirs:
      - src
    files:
      - src/vec_isa_pkg.sv
      - src/vec_field_stage.sv
      - src/vec_opi_table.sv
      - src/vec_opm_table.sv
      - src/vec_ctrl_stage.sv
      - src/vec_decode_top.sv
  - target: test
    include_dirs:
      - src
      - dv
    files:
      - dv/vec_decode_assertions.sv
      - dv/vec_decode_tb.sv

// File: dv/vec_decode_assertions.sv
module vec_decode_assertions (
  input logic        clk,
  input logic        rst,
  input logic        out_valid,
  input logic        out_ready,
  input logic [68:0] out_bits
);

  // synchronous reset clears the output slot
  assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  assert property (@(posedge clk) disable iff (rst)
                   (out_valid && !out_ready) |=> $stable(out_bits))
    else $error("decoded outputs changed while stalled");

  assert property (@(posedge clk) disable iff (rst)
                   (out_valid && !out_ready) |=> out_valid)
    else $error("out_valid fell without out_ready");

endmodule

bind vec_decode_top vec_decode_assertions u_handshake_check (
  .clk       (clk),
  .rst       (rst),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_bits  ({illegal, de_en, vd, vs1, vs2, cfgsel, fu_type, aluop, comp_type,
               minmax_type, is_signed, rs1_type, imm, high_low, div_rem})
);

// File: dv/vec_decode_model.svh
`ifndef VEC_DECODE_MODEL_SVH
`define VEC_DECODE_MODEL_SVH

// expected outputs for one instruction word, packed as
// {illegal, de_en, vd, vs1, vs2, cfgsel, fu_type, aluop, comp_type,
//  minmax_type, is_signed, rs1_type, imm, high_low, div_rem}
function automatic logic [68:0] decode_model(input logic [31:0] w);
  logic [5:0]  f6;
  logic [2:0]  f3;
  logic        opv;
  logic        is_opi;
  logic        is_opm;
  // allowed forms, {vv, vx, vi}
  logic [2:0]  forms;
  logic        legal;
  logic [1:0]  cfg;
  logic [2:0]  fu;
  logic [3:0]  alu;
  logic [2:0]  cmp;
  logic [1:0]  mm;
  logic [1:0]  sgn;
  logic [1:0]  src;
  logic        zext;
  logic        hl;
  logic        dr;
  logic [31:0] imm;
  f6 = w[31:26];
  f3 = w[14:12];
  opv = (w[6:0] == `VEC_OPCODE_V);
  is_opi = opv && (f3 == `F3_OPIVV || f3 == `F3_OPIVX || f3 == `F3_OPIVI);
  is_opm = opv && (f3 == `F3_OPMVV || f3 == `F3_OPMVX);
  forms = 3'b000;
  legal = 1'b0;
  cfg = `CFG_NONE;
  fu = `FU_ARITH;
  alu = `ALU_ADD;
  cmp = `CMP_EQ;
  mm = `MM_MIN;
  sgn = `SGN_UNSIGNED;
  zext = 1'b0;
  hl = 1'b0;
  dr = 1'b0;
  if (opv && f3 == `F3_OPCFG) begin
    cfg = !w[31] ? `CFG_VSETVLI : (w[30] ? `CFG_VSETIVLI : `CFG_VSETVL);
  end
  if (is_opi) begin
    case (f6)
      6'b000000, 6'b001001, 6'b001010, 6'b001011, 6'b011000, 6'b011001,
      6'b011100, 6'b011101, 6'b100101, 6'b101000, 6'b101001: forms = 3'b111;
      6'b000010, 6'b000100, 6'b000101, 6'b000110, 6'b000111,
      6'b011010, 6'b011011: forms = 3'b110;
      6'b000011, 6'b011110, 6'b011111: forms = 3'b011;
      default: forms = 3'b000;
    endcase
    legal = (f3 == `F3_OPIVV && forms[2]) || (f3 == `F3_OPIVX && forms[1]) ||
            (f3 == `F3_OPIVI && forms[0]);
  end
  // reductions are .vs only, multiply and divide take vv or vx
  if (is_opm) begin
    legal = (f6[5:3] == 3'b000 && f3 == `F3_OPMVV) || (f6[5:3] == 3'b100);
  end
  if (legal && is_opi) begin
    case (f6)
      6'b000010, 6'b000011: alu = `ALU_SUB;
      6'b000100, 6'b000101, 6'b000110, 6'b000111: alu = `ALU_MM;
      6'b001001: alu = `ALU_AND;
      6'b001010: alu = `ALU_OR;
      6'b001011: alu = `ALU_XOR;
      6'b011000, 6'b011001, 6'b011010, 6'b011011,
      6'b011100, 6'b011101, 6'b011110, 6'b011111: alu = `ALU_COMP;
      6'b100101: alu = `ALU_SLL;
      6'b101000: alu = `ALU_SRL;
      6'b101001: alu = `ALU_SRA;
      default: alu = `ALU_ADD;
    endcase
    case (f6)
      6'b011001: cmp = `CMP_NE;
      6'b011010: cmp = `CMP_LTU;
      6'b011011: cmp = `CMP_LT;
      6'b011100: cmp = `CMP_LEU;
      6'b011101: cmp = `CMP_LE;
      6'b011110: cmp = `CMP_GTU;
      6'b011111: cmp = `CMP_GT;
      default: cmp = `CMP_EQ;
    endcase
    zext = f6 inside {6'b100101, 6'b101000, 6'b101001};
    if (f6 inside {6'b000000, 6'b000010, 6'b000011, 6'b000101, 6'b000111,
                   6'b011000, 6'b011001, 6'b011011, 6'b011101, 6'b011111}) begin
      sgn = `SGN_SIGNED;
    end
  end
  if (legal && is_opm) begin
    case (f6)
      6'b000001: alu = `ALU_AND;
      6'b000010: alu = `ALU_OR;
      6'b000011: alu = `ALU_XOR;
      6'b000100, 6'b000101, 6'b000110, 6'b000111: alu = `ALU_MM;
      default: alu = `ALU_ADD;
    endcase
    if (f6[5:3] == 3'b000) begin
      fu = `FU_RED;
    end else if (f6[5:2] == 4'b1001) begin
      fu = `FU_MUL;
    end else begin
      fu = `FU_DIV;
    end
    hl = f6 inside {6'b100100, 6'b100110, 6'b100111};
    dr = f6 inside {6'b100000, 6'b100001};
    if (f6 == 6'b100110) begin
      sgn = `SGN_SIGNED_UNSIGNED;
    end else if (f6 inside {6'b000000, 6'b000101, 6'b000111, 6'b100101, 6'b100111,
                            6'b100001, 6'b100011}) begin
      sgn = `SGN_SIGNED;
    end
  end
  // min/max and their reductions share funct6 values
  if (legal) begin
    case (f6)
      6'b000100: mm = `MM_MINU;
      6'b000110: mm = `MM_MAXU;
      6'b000111: mm = `MM_MAX;
      default: mm = `MM_MIN;
    endcase
  end
  if (!legal) begin
    fu = `FU_NONE;
  end
  if (cfg == `CFG_VSETVLI || cfg == `CFG_VSETVL) begin
    src = `SRC_X;
  end else if (cfg == `CFG_VSETIVLI) begin
    src = `SRC_I;
  end else if (legal && (f3 == `F3_OPIVX || f3 == `F3_OPMVX)) begin
    src = `SRC_X;
  end else if (legal && f3 == `F3_OPIVI) begin
    src = `SRC_I;
  end else begin
    src = `SRC_V;
  end
  zext = zext || (cfg == `CFG_VSETIVLI);
  imm = zext ? {27'd0, w[19:15]} : {{27{w[19]}}, w[19:15]};
  return {!legal && cfg == `CFG_NONE, legal, w[11:7], w[19:15], w[24:20], cfg, fu,
          alu, cmp, mm, sgn, src, imm, hl, dr};
endfunction

`endif

// File: dv/vec_decode_tb.sv
`include "vec_decode_macros.svh"

module vec_decode_tb;

  localparam int NUM_INSTR = 2000;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic        in_ready;
  logic [31:0] instr;
  logic        out_valid;
  logic        out_ready;
  logic        illegal;
  logic        de_en;
  logic [4:0]  vd;
  logic [4:0]  vs1;
  logic [4:0]  vs2;
  logic [1:0]  cfgsel;
  logic [2:0]  fu_type;
  logic [3:0]  aluop;
  logic [2:0]  comp_type;
  logic [1:0]  minmax_type;
  logic [1:0]  is_signed;
  logic [1:0]  rs1_type;
  logic [31:0] imm;
  logic        high_low;
  logic        div_rem;

  logic [31:0] lcg_state;
  logic [68:0] exp_q[$];
  logic [31:0] word_q[$];
  int          accepted;
  int          retired;

  `include "vec_decode_model.svh"

  vec_decode_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .instr       (instr),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .illegal     (illegal),
    .de_en       (de_en),
    .vd          (vd),
    .vs1         (vs1),
    .vs2         (vs2),
    .cfgsel      (cfgsel),
    .fu_type     (fu_type),
    .aluop       (aluop),
    .comp_type   (comp_type),
    .minmax_type (minmax_type),
    .is_signed   (is_signed),
    .rs1_type    (rs1_type),
    .imm         (imm),
    .high_low    (high_low),
    .div_rem     (div_rem)
  );

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  // mostly OP-V, funct6 mostly from the decoded families
  function automatic logic [31:0] make_instr();
    logic [31:0] w;
    logic [15:0] r;
    w[31:16] = next_rand();
    w[15:0] = next_rand();
    r = next_rand();
    if (r[3:0] != 4'd0) begin
      w[6:0] = `VEC_OPCODE_V;
    end
    if (r[7:4] < 4'd12) begin
      case (r[11:8] % 5)
        0: w[31:29] = 3'b000;
        1: w[31:29] = 3'b011;
        2: w[31:29] = 3'b100;
        3: w[31:26] = 6'b001001 + 6'(r[13:12] % 3);
        default: w[31:26] = {5'b10100, r[14]};
      endcase
    end
    return w;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_field(input string name, input logic [31:0] word,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      report_failure($sformatf("ERR decode_%s instr %08h: expected %0h, actual %0h",
                               name, word, exp, act));
    end
  endtask

  task automatic compare_outputs(input logic [68:0] exp, input logic [31:0] word);
    check_field("illegal", word, 32'(exp[68]), 32'(illegal));
    check_field("de_en", word, 32'(exp[67]), 32'(de_en));
    check_field("vd", word, 32'(exp[66:62]), 32'(vd));
    check_field("vs1", word, 32'(exp[61:57]), 32'(vs1));
    check_field("vs2", word, 32'(exp[56:52]), 32'(vs2));
    check_field("cfgsel", word, 32'(exp[51:50]), 32'(cfgsel));
    check_field("fu_type", word, 32'(exp[49:47]), 32'(fu_type));
    check_field("aluop", word, 32'(exp[46:43]), 32'(aluop));
    check_field("comp_type", word, 32'(exp[42:40]), 32'(comp_type));
    check_field("minmax_type", word, 32'(exp[39:38]), 32'(minmax_type));
    check_field("is_signed", word, 32'(exp[37:36]), 32'(is_signed));
    check_field("rs1_type", word, 32'(exp[35:34]), 32'(rs1_type));
    check_field("imm", word, exp[33:2], imm);
    check_field("high_low", word, 32'(exp[1]), 32'(high_low));
    check_field("div_rem", word, 32'(exp[0]), 32'(div_rem));
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // generous bound, each instruction drains in far fewer than 20 cycles
  initial begin
    repeat (NUM_INSTR * 20 + 100) @(posedge clk);
    report_failure($sformatf("timeout, only %0d of %0d instructions came out",
                             retired, NUM_INSTR));
  end

  initial begin
    logic hold;
    logic stalled;
    int   cycle;
    int   first_acc;
    lcg_state = 32'd88251;
    rst = 1'b1;
    in_valid = 1'b0;
    out_ready = 1'b0;
    instr = '0;
    accepted = 0;
    retired = 0;
    hold = 1'b0;
    stalled = 1'b0;
    cycle = 0;
    first_acc = -1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (retired < NUM_INSTR) begin
      // a refused word stays on the bus
      if (!hold) begin
        in_valid = (accepted < NUM_INSTR) && (next_rand() % 10 < 7);
        instr = make_instr();
      end
      out_ready = (next_rand() % 10) < 7;
      #1;
      // refused only with both slots taken and the output stalled
      check_field("in_ready", instr, 32'((exp_q.size() < 2) || out_ready),
                  32'(in_ready));
      // first word lands in stage 1 at the edge, in the output one edge later
      if (first_acc < 0 || cycle == first_acc + 1) begin
        assert (!out_valid) else begin
          report_failure("out_valid was high before the first instruction could get there");
        end
      end else if (cycle == first_acc + 2) begin
        assert (out_valid) else begin
          report_failure("the first instruction did not reach the output in time");
        end
      end
      if (stalled) begin
        assert (out_valid) else begin
          report_failure("out_valid dropped while out_ready was low");
        end
      end
      if (out_valid) begin
        assert (exp_q.size() > 0) else begin
          report_failure("out_valid was high with no instruction outstanding");
        end
        compare_outputs(exp_q[0], word_q[0]);
        if (out_ready) begin
          void'(exp_q.pop_front());
          void'(word_q.pop_front());
          retired++;
        end
      end
      stalled = out_valid && !out_ready;
      if (in_valid && in_ready) begin
        exp_q.push_back(decode_model(instr));
        word_q.push_back(instr);
        accepted++;
        if (first_acc < 0) begin
          first_acc = cycle;
        end
      end
      hold = in_valid && !in_ready;
      cycle++;
      @(negedge clk);
    end
    // nothing more may come out once every word has left
    in_valid = 1'b0;
    out_ready = 1'b1;
    repeat (4) begin
      #1;
      assert (!out_valid) else begin
        report_failure("out_valid was high after every instruction had come out");
      end
      @(negedge clk);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// File: src/vec_ctrl_stage.sv
`include "vec_decode_macros.svh"

module vec_ctrl_stage
  import vec_isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  s1_valid,
  output logic                  s1_ready,
  input  vec_instr_u            s1_instr,
  input  logic [1:0]            s1_cfgsel,
  input  logic [`VEC_OP_W-1:0]  opi_op,
  input  logic [`VEC_OP_W-1:0]  opm_op,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic                  illegal,
  output logic                  de_en,
  output logic [`VEC_REG_W-1:0] vd,
  output logic [`VEC_REG_W-1:0] vs1,
  output logic [`VEC_REG_W-1:0] vs2,
  output logic [1:0]            cfgsel,
  output logic [2:0]            fu_type,
  output logic [3:0]            aluop,
  output logic [2:0]            comp_type,
  output logic [1:0]            minmax_type,
  output logic [1:0]            is_signed,
  output logic [1:0]            rs1_type,
  output logic [`VEC_ILEN-1:0]  imm,
  output logic                  high_low,
  output logic                  div_rem
);

  logic [`VEC_OP_W-1:0] op;
  logic                 illegal_d;
  logic                 de_en_d;
  logic                 is_red;
  logic                 is_mul;
  logic                 is_div;
  logic                 is_shift;
  logic [2:0]           f3;
  logic [2:0]           fu_d;
  logic [3:0]           alu_d;
  logic [2:0]           cmp_d;
  logic [1:0]           mm_d;
  logic [1:0]           sgn_d;
  logic [1:0]           src_d;
  logic [`VEC_ILEN-1:0] imm_d;

  // the tables never both hit
  assign op        = (opi_op != `OP_BAD) ? opi_op : opm_op;
  assign illegal_d = (op == `OP_BAD) && (s1_cfgsel == `CFG_NONE);
  assign de_en_d   = !illegal_d && (s1_cfgsel == `CFG_NONE);
  assign f3        = s1_instr.arith.funct3;

  assign is_red   = op inside {[`OP_VREDSUM:`OP_VREDMAX]};
  assign is_div   = op inside {[`OP_VDIVU:`OP_VREM]};
  assign is_mul   = op inside {[`OP_VMULHU:`OP_VMULH]};
  assign is_shift = op inside {`OP_VSLL, `OP_VSRL, `OP_VSRA};

  always_comb begin
    if (!de_en_d) begin
      fu_d = `FU_NONE;
    end else if (is_red) begin
      fu_d = `FU_RED;
    end else if (is_mul) begin
      fu_d = `FU_MUL;
    end else if (is_div) begin
      fu_d = `FU_DIV;
    end else begin
      fu_d = `FU_ARITH;
    end
  end

  always_comb begin
    case (op)
      `OP_VSUB, `OP_VRSUB:    alu_d = `ALU_SUB;
      `OP_VAND, `OP_VREDAND:  alu_d = `ALU_AND;
      `OP_VOR, `OP_VREDOR:    alu_d = `ALU_OR;
      `OP_VXOR, `OP_VREDXOR:  alu_d = `ALU_XOR;
      `OP_VSLL:               alu_d = `ALU_SLL;
      `OP_VSRL:               alu_d = `ALU_SRL;
      `OP_VSRA:               alu_d = `ALU_SRA;
      `OP_VMSEQ, `OP_VMSNE, `OP_VMSLTU, `OP_VMSLT,
      `OP_VMSLEU, `OP_VMSLE, `OP_VMSGTU, `OP_VMSGT: alu_d = `ALU_COMP;
      `OP_VMINU, `OP_VMIN, `OP_VMAXU, `OP_VMAX,
      `OP_VREDMINU, `OP_VREDMIN, `OP_VREDMAXU, `OP_VREDMAX: alu_d = `ALU_MM;
      default:                alu_d = `ALU_ADD;
    endcase
  end

  always_comb begin
    case (op)
      `OP_VMSNE:  cmp_d = `CMP_NE;
      `OP_VMSLTU: cmp_d = `CMP_LTU;
      `OP_VMSLT:  cmp_d = `CMP_LT;
      `OP_VMSLEU: cmp_d = `CMP_LEU;
      `OP_VMSLE:  cmp_d = `CMP_LE;
      `OP_VMSGTU: cmp_d = `CMP_GTU;
      `OP_VMSGT:  cmp_d = `CMP_GT;
      default:    cmp_d = `CMP_EQ;
    endcase
  end

  always_comb begin
    case (op)
      `OP_VMINU, `OP_VREDMINU: mm_d = `MM_MINU;
      `OP_VMAX, `OP_VREDMAX:   mm_d = `MM_MAX;
      `OP_VMAXU, `OP_VREDMAXU: mm_d = `MM_MAXU;
      default:                 mm_d = `MM_MIN;
    endcase
  end

  always_comb begin
    case (op)
      `OP_VADD, `OP_VSUB, `OP_VRSUB, `OP_VMIN, `OP_VMAX,
      `OP_VMSEQ, `OP_VMSNE, `OP_VMSLT, `OP_VMSLE, `OP_VMSGT,
      `OP_VREDSUM, `OP_VREDMIN, `OP_VREDMAX,
      `OP_VMUL, `OP_VMULH, `OP_VDIV, `OP_VREM: sgn_d = `SGN_SIGNED;
      `OP_VMULHSU:                             sgn_d = `SGN_SIGNED_UNSIGNED;
      default:                                 sgn_d = `SGN_UNSIGNED;
    endcase
  end

  // scalar for .vx and the vl register forms, immediate for .vi and vsetivli
  always_comb begin
    src_d = `SRC_V;
    case (s1_cfgsel)
      `CFG_VSETVLI, `CFG_VSETVL: src_d = `SRC_X;
      `CFG_VSETIVLI:             src_d = `SRC_I;
      default: begin
        if (de_en_d && ((f3 == `F3_OPIVX) || (f3 == `F3_OPMVX))) begin
          src_d = `SRC_X;
        end else if (de_en_d && (f3 == `F3_OPIVI)) begin
          src_d = `SRC_I;
        end
      end
    endcase
  end

  // shift amounts and avl are unsigned
  assign imm_d = (is_shift || (s1_cfgsel == `CFG_VSETIVLI)) ?
                 {{(`VEC_ILEN - `VEC_REG_W){1'b0}}, s1_instr.arith.vs1} :
                 {{(`VEC_ILEN - `VEC_REG_W){s1_instr.arith.vs1[`VEC_REG_W-1]}},
                  s1_instr.arith.vs1};

  assign s1_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (s1_ready) begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid && s1_ready) begin
      illegal     <= illegal_d;
      de_en       <= de_en_d;
      vd          <= s1_instr.arith.vd;
      vs1         <= s1_instr.arith.vs1;
      vs2         <= s1_instr.arith.vs2;
      cfgsel      <= s1_cfgsel;
      fu_type     <= fu_d;
      aluop       <= alu_d;
      comp_type   <= cmp_d;
      minmax_type <= mm_d;
      is_signed   <= sgn_d;
      rs1_type    <= src_d;
      imm         <= imm_d;
      high_low    <= op inside {`OP_VMULH, `OP_VMULHU, `OP_VMULHSU};
      div_rem     <= op inside {`OP_VDIVU, `OP_VDIV};
    end
  end

endmodule

// File: src/vec_decode_macros.svh
`ifndef VEC_DECODE_MACROS_SVH
`define VEC_DECODE_MACROS_SVH

// widths
`define VEC_ILEN 32
`define VEC_REG_W 5
`define VEC_OP_W 6

// major opcode and funct3 categories
`define VEC_OPCODE_V 7'b1010111
`define F3_OPIVV 3'b000
`define F3_OPMVV 3'b010
`define F3_OPIVI 3'b011
`define F3_OPIVX 3'b100
`define F3_OPMVX 3'b110
`define F3_OPCFG 3'b111

// funct6, single ops and casez families (low bits pick the member)
`define F6_VADD 6'b000000
`define F6_VSUB 6'b000010
`define F6_VRSUB 6'b000011
`define F6_MINMAX 6'b0001??
`define F6_VAND 6'b001001
`define F6_VOR 6'b001010
`define F6_VXOR 6'b001011
`define F6_CMP 6'b011???
`define F6_VSLL 6'b100101
`define F6_VSRL 6'b101000
`define F6_VSRA 6'b101001
`define F6_RED 6'b000???
`define F6_DIV 6'b1000??
`define F6_MUL 6'b1001??

// functional unit select
`define FU_ARITH 3'd0
`define FU_RED 3'd1
`define FU_MUL 3'd2
`define FU_DIV 3'd3
`define FU_NONE 3'd4

// alu operation
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_OR 4'd3
`define ALU_XOR 4'd4
`define ALU_SLL 4'd5
`define ALU_SRL 4'd6
`define ALU_SRA 4'd7
`define ALU_COMP 4'd8
`define ALU_MM 4'd9

// compare kind
`define CMP_EQ 3'd0
`define CMP_NE 3'd1
`define CMP_LTU 3'd2
`define CMP_LT 3'd3
`define CMP_LEU 3'd4
`define CMP_LE 3'd5
`define CMP_GTU 3'd6
`define CMP_GT 3'd7

// min/max kind
`define MM_MIN 2'd0
`define MM_MINU 2'd1
`define MM_MAX 2'd2
`define MM_MAXU 2'd3

// signedness of the operands
`define SGN_UNSIGNED 2'd0
`define SGN_SIGNED 2'd1
`define SGN_SIGNED_UNSIGNED 2'd2

// kind of source 1
`define SRC_V 2'd0
`define SRC_X 2'd1
`define SRC_I 2'd2

// configuration form
`define CFG_NONE 2'd0
`define CFG_VSETVLI 2'd1
`define CFG_VSETIVLI 2'd2
`define CFG_VSETVL 2'd3

// internal op index, families kept contiguous in funct6 order
`define OP_VADD 6'd0
`define OP_VSUB 6'd1
`define OP_VRSUB 6'd2
`define OP_VMINU 6'd3
`define OP_VMIN 6'd4
`define OP_VMAXU 6'd5
`define OP_VMAX 6'd6
`define OP_VAND 6'd7
`define OP_VOR 6'd8
`define OP_VXOR 6'd9
`define OP_VMSEQ 6'd10
`define OP_VMSNE 6'd11
`define OP_VMSLTU 6'd12
`define OP_VMSLT 6'd13
`define OP_VMSLEU 6'd14
`define OP_VMSLE 6'd15
`define OP_VMSGTU 6'd16
`define OP_VMSGT 6'd17
`define OP_VSLL 6'd18
`define OP_VSRL 6'd19
`define OP_VSRA 6'd20
`define OP_VREDSUM 6'd21
`define OP_VREDAND 6'd22
`define OP_VREDOR 6'd23
`define OP_VREDXOR 6'd24
`define OP_VREDMINU 6'd25
`define OP_VREDMIN 6'd26
`define OP_VREDMAXU 6'd27
`define OP_VREDMAX 6'd28
`define OP_VDIVU 6'd29
`define OP_VDIV 6'd30
`define OP_VREMU 6'd31
`define OP_VREM 6'd32
`define OP_VMULHU 6'd33
`define OP_VMUL 6'd34
`define OP_VMULHSU 6'd35
`define OP_VMULH 6'd36
`define OP_BAD 6'd63

`endif

// File: src/vec_decode_top.sv
`include "vec_decode_macros.svh"

module vec_decode_top
  import vec_isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [`VEC_ILEN-1:0]  instr,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic                  illegal,
  output logic                  de_en,
  output logic [`VEC_REG_W-1:0] vd,
  output logic [`VEC_REG_W-1:0] vs1,
  output logic [`VEC_REG_W-1:0] vs2,
  output logic [1:0]            cfgsel,
  output logic [2:0]            fu_type,
  output logic [3:0]            aluop,
  output logic [2:0]            comp_type,
  output logic [1:0]            minmax_type,
  output logic [1:0]            is_signed,
  output logic [1:0]            rs1_type,
  output logic [`VEC_ILEN-1:0]  imm,
  output logic                  high_low,
  output logic                  div_rem
);

  // stage 1 to stage 2
  logic                 s1_valid;
  logic                 s1_ready;
  vec_instr_u           s1_instr;
  logic                 s1_is_opi;
  logic                 s1_is_opm;
  logic [1:0]           s1_cfgsel;
  logic [`VEC_OP_W-1:0] opi_op;
  logic [`VEC_OP_W-1:0] opm_op;

  vec_field_stage u_field (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .instr     (instr),
    .s1_valid  (s1_valid),
    .s1_ready  (s1_ready),
    .s1_instr  (s1_instr),
    .s1_is_opi (s1_is_opi),
    .s1_is_opm (s1_is_opm),
    .s1_cfgsel (s1_cfgsel)
  );

  // lookups run on the stage 1 registers
  vec_opi_table u_opi (
    .instr  (s1_instr),
    .is_opi (s1_is_opi),
    .op     (opi_op)
  );

  vec_opm_table u_opm (
    .instr  (s1_instr),
    .is_opm (s1_is_opm),
    .op     (opm_op)
  );

  vec_ctrl_stage u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .s1_valid    (s1_valid),
    .s1_ready    (s1_ready),
    .s1_instr    (s1_instr),
    .s1_cfgsel   (s1_cfgsel),
    .opi_op      (opi_op),
    .opm_op      (opm_op),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .illegal     (illegal),
    .de_en       (de_en),
    .vd          (vd),
    .vs1         (vs1),
    .vs2         (vs2),
    .cfgsel      (cfgsel),
    .fu_type     (fu_type),
    .aluop       (aluop),
    .comp_type   (comp_type),
    .minmax_type (minmax_type),
    .is_signed   (is_signed),
    .rs1_type    (rs1_type),
    .imm         (imm),
    .high_low    (high_low),
    .div_rem     (div_rem)
  );

endmodule

// File: src/vec_field_stage.sv
`include "vec_decode_macros.svh"

module vec_field_stage
  import vec_isa_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  output logic       in_ready,
  input  vec_instr_u instr,
  output logic       s1_valid,
  input  logic       s1_ready,
  output vec_instr_u s1_instr,
  output logic       s1_is_opi,
  output logic       s1_is_opm,
  output logic [1:0] s1_cfgsel
);

  logic       is_opv;
  logic [2:0] f3;
  logic       is_opi;
  logic       is_opm;
  logic [1:0] cfgsel;

  assign is_opv = (instr.arith.opcode == `VEC_OPCODE_V);
  assign f3     = instr.arith.funct3;

  assign is_opi = is_opv &&
                  ((f3 == `F3_OPIVV) || (f3 == `F3_OPIVX) || (f3 == `F3_OPIVI));
  assign is_opm = is_opv && ((f3 == `F3_OPMVV) || (f3 == `F3_OPMVX));

  // vsetvli has bit 31 clear, the other two use bit 30
  always_comb begin
    cfgsel = `CFG_NONE;
    if (is_opv && (f3 == `F3_OPCFG)) begin
      if (!instr.cfg.b31) begin
        cfgsel = `CFG_VSETVLI;
      end else if (instr.cfg.b30) begin
        cfgsel = `CFG_VSETIVLI;
      end else begin
        cfgsel = `CFG_VSETVL;
      end
    end
  end

  // free slot, or the slot drains this cycle
  assign in_ready = !s1_valid || s1_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (in_ready) begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      s1_instr  <= instr;
      s1_is_opi <= is_opi;
      s1_is_opm <= is_opm;
      s1_cfgsel <= cfgsel;
    end
  end

endmodule

// File: src/vec_isa_pkg.sv
`include "vec_decode_macros.svh"

package vec_isa_pkg;

  // OP-V arithmetic layout
  typedef struct packed {
    logic [5:0]            funct6;
    logic                  vm;
    logic [`VEC_REG_W-1:0] vs2;
    logic [`VEC_REG_W-1:0] vs1;
    logic [2:0]            funct3;
    logic [`VEC_REG_W-1:0] vd;
    logic [6:0]            opcode;
  } vec_arith_t;

  // vset* layout, the top two bits pick the form
  typedef struct packed {
    logic                  b31;
    logic                  b30;
    logic [9:0]            zimm;
    logic [`VEC_REG_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`VEC_REG_W-1:0] rd;
    logic [6:0]            opcode;
  } vec_cfg_t;

  typedef union packed {
    vec_arith_t arith;
    vec_cfg_t   cfg;
  } vec_instr_u;

endpackage

// File: src/vec_opi_table.sv
`include "vec_decode_macros.svh"

module vec_opi_table
  import vec_isa_pkg::*;
(
  input  vec_instr_u            instr,
  input  logic                  is_opi,
  output logic [`VEC_OP_W-1:0]  op
);

  logic [5:0]           f6;
  logic [`VEC_OP_W-1:0] base;
  // one bit per form, {vi, vx, vv}
  logic [2:0]           form;
  logic [2:0]           allowed;

  assign f6   = instr.arith.funct6;
  assign form = {instr.arith.funct3 == `F3_OPIVI,
                 instr.arith.funct3 == `F3_OPIVX,
                 instr.arith.funct3 == `F3_OPIVV};

  always_comb begin
    base = `OP_BAD;
    casez (f6)
      `F6_VADD:   base = `OP_VADD;
      `F6_VSUB:   base = `OP_VSUB;
      `F6_VRSUB:  base = `OP_VRSUB;
      `F6_MINMAX: base = `OP_VMINU + {4'd0, f6[1:0]};
      `F6_VAND:   base = `OP_VAND;
      `F6_VOR:    base = `OP_VOR;
      `F6_VXOR:   base = `OP_VXOR;
      `F6_CMP:    base = `OP_VMSEQ + {3'd0, f6[2:0]};
      `F6_VSLL:   base = `OP_VSLL;
      `F6_VSRL:   base = `OP_VSRL;
      `F6_VSRA:   base = `OP_VSRA;
      default:    base = `OP_BAD;
    endcase
  end

  always_comb begin
    allowed = 3'b000;
    casez (f6)
      `F6_VADD, `F6_VAND, `F6_VOR, `F6_VXOR,
      `F6_VSLL, `F6_VSRL, `F6_VSRA: allowed = 3'b111;
      `F6_VSUB, `F6_MINMAX:         allowed = 3'b011;
      `F6_VRSUB:                    allowed = 3'b110;
      // lt has no vi form, gt has no vv form
      `F6_CMP: begin
        if (f6[2:1] == 2'b01) begin
          allowed = 3'b011;
        end else if (f6[2:1] == 2'b11) begin
          allowed = 3'b110;
        end else begin
          allowed = 3'b111;
        end
      end
      default: allowed = 3'b000;
    endcase
  end

  assign op = (is_opi && |(allowed & form)) ? base : `OP_BAD;

endmodule

// File: src/vec_opm_table.sv
`include "vec_decode_macros.svh"

module vec_opm_table
  import vec_isa_pkg::*;
(
  input  vec_instr_u            instr,
  input  logic                  is_opm,
  output logic [`VEC_OP_W-1:0]  op
);

  logic [5:0] f6;
  logic       is_vv;

  assign f6    = instr.arith.funct6;
  assign is_vv = (instr.arith.funct3 == `F3_OPMVV);

  // is_opm already limits funct3 to mvv or mvx
  always_comb begin
    op = `OP_BAD;
    if (is_opm) begin
      casez (f6)
        // reductions exist only as .vs with a vector source
        `F6_RED: begin
          if (is_vv) begin
            op = `OP_VREDSUM + {3'd0, f6[2:0]};
          end
        end
        `F6_DIV: op = `OP_VDIVU + {4'd0, f6[1:0]};
        `F6_MUL: op = `OP_VMULHU + {4'd0, f6[1:0]};
        default: op = `OP_BAD;
      endcase
    end
  end

endmodule

// File: vec_decode_top.f
+incdir+src
+incdir+dv
src/vec_isa_pkg.sv
src/vec_field_stage.sv
src/vec_opi_table.sv
src/vec_opm_table.sv
src/vec_ctrl_stage.sv
src/vec_decode_top.sv
dv/vec_decode_assertions.sv
dv/vec_decode_tb.sv
